// File: logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int XLen      = 32;
    localparam int ImemDepth = 256;              // Words
    localparam int DmemDepth = 256;              // Words
    localparam int WordAw    = $clog2(DmemDepth); // Word address bits of both memories
    localparam int PaddrW    = 16;               // APB address width

    // Host address map in byte addresses
    localparam logic [PaddrW-1:0] ImemBase = 16'h0000;
    localparam logic [PaddrW-1:0] DmemBase = 16'h1000;
    localparam logic [PaddrW-1:0] CtrlAddr = 16'h2000; // Bit 0 is run
    localparam logic [PaddrW-1:0] PcAddr   = 16'h2004; // Read only

    typedef enum logic [6:0] {
        OpR      = 7'b0110011,
        OpImm    = 7'b0010011,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpBranch = 7'b1100011
    } opcodeT;

    typedef enum logic [2:0] {
        AluAdd = 3'd0,
        AluSub = 3'd1,
        AluAnd = 3'd2,
        AluOr  = 3'd3,
        AluSlt = 3'd4
    } aluOpT;

    typedef struct packed {
        logic  regWrite;
        logic  aluSrc;   // 1 selects the immediate
        logic  memRead;
        logic  memWrite;
        logic  memToReg; // Write back load data
        logic  branch;
        aluOpT aluOp;
    } ctrlT;

    // Decoder output for anything outside the subset
    localparam ctrlT CtrlNop = '{
        regWrite: 1'b0,
        aluSrc:   1'b0,
        memRead:  1'b0,
        memWrite: 1'b0,
        memToReg: 1'b0,
        branch:   1'b0,
        aluOp:    AluAdd
    };

    typedef struct packed {
        logic              valid;
        logic              write;
        logic [WordAw-1:0] addr;  // Word address
        logic [XLen-1:0]   wdata;
    } memReqT;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [PaddrW-1:0] paddr;
        logic [XLen-1:0]   pwdata;
    } apbReqT;

    typedef struct packed {
        logic [XLen-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apbRspT;

endpackage

`default_nettype wire

// File: logic/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile import cpuPkg::*; (
    input  wire logic            CLK,
    input  wire logic            rstN,
    input  wire logic [4:0]      rdAddr1,
    input  wire logic [4:0]      rdAddr2,
    input  wire logic [4:0]      wrAddr,
    input  wire logic            wrEn,
    input  wire logic [XLen-1:0] wrData,
    output logic      [XLen-1:0] rdData1,
    output logic      [XLen-1:0] rdData2
);

    logic [XLen-1:0] regs [32];

    // Single write port, x0 never written
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Async reads, x0 hardwired to zero
    assign rdData1 = (rdAddr1 == 5'd0) ? '0 : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == 5'd0) ? '0 : regs[rdAddr2];

endmodule

`default_nettype wire

// File: logic/instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecoder import cpuPkg::*; (
    input  wire logic [XLen-1:0] instr,
    output ctrlT                 ctrl,
    output logic      [XLen-1:0] imm
);

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b5;

    assign opcode   = opcodeT'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30]; // Sub select on R-type

    // funct3 to ALU op, subBit only meaningful for R-type
    function automatic aluOpT aluSel(input logic [2:0] f3, input logic subBit);
        case (f3)
            3'b000:  return subBit ? AluSub : AluAdd;
            3'b010:  return AluSlt;
            3'b110:  return AluOr;
            3'b111:  return AluAnd;
            default: return AluAdd;
        endcase
    endfunction

    always_comb begin
        ctrl = CtrlNop;
        case (opcode)
            OpR: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluSel(funct3, funct7b5);
            end
            OpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluSel(funct3, 1'b0); // No subi
            end
            OpLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            OpStore: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OpBranch: begin
                // Only beq, compare by subtract
                ctrl.branch = (funct3 == 3'b000);
                ctrl.aluOp  = AluSub;
            end
            default: ctrl = CtrlNop;
        endcase
    end

    // Immediate formats, all sign extended
    always_comb begin
        case (opcode)
            OpStore:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OpBranch: imm = {{19{instr[31]}}, instr[31], instr[7],
                             instr[30:25], instr[11:8], 1'b0}; // Already x2
            default:  imm = {{20{instr[31]}}, instr[31:20]};   // I-type
        endcase
    end

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import cpuPkg::*; (
    input  wire logic [XLen-1:0] a,
    input  wire logic [XLen-1:0] b,
    input  wire aluOpT           op,
    output logic      [XLen-1:0] y,
    output logic                 zero
);

    always_comb begin
        case (op)
            AluAdd:  y = a + b;
            AluSub:  y = a - b;
            AluAnd:  y = a & b;
            AluOr:   y = a | b;
            AluSlt:  y = {{(XLen-1){1'b0}}, $signed(a) < $signed(b)}; // Signed compare
            default: y = a + b;
        endcase
    end

    assign zero = (y == '0); // beq condition

endmodule

`default_nettype wire

// File: logic/coreDatapath.sv
`timescale 1ns/10ps
`default_nettype none

module coreDatapath import cpuPkg::*; (
    input  wire logic            CLK,
    input  wire logic            rstN,
    input  wire logic            run,
    input  wire logic            pcClear,
    input  wire logic [XLen-1:0] instr,
    output logic      [XLen-1:0] pc,
    output memReqT               memReq,
    input  wire logic            grant,
    input  wire logic [XLen-1:0] memRdata
);

    ctrlT            ctrl;
    logic [XLen-1:0] imm;
    logic [XLen-1:0] rs1Data;
    logic [XLen-1:0] rs2Data;
    logic [XLen-1:0] aluB;
    logic [XLen-1:0] aluY;
    logic            aluZero;
    logic [XLen-1:0] wbData;
    logic [XLen-1:0] nextPc;
    logic            takeBranch;
    logic            stall;
    logic            advance;

    instrDecoder uDecoder (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    regFile uRegFile (
        .CLK     (CLK),
        .rstN    (rstN),
        .rdAddr1 (instr[19:15]),
        .rdAddr2 (instr[24:20]),
        .wrAddr  (instr[11:7]),
        .wrEn    (advance & ctrl.regWrite), // Nothing retires on a stall
        .wrData  (wbData),
        .rdData1 (rs1Data),
        .rdData2 (rs2Data)
    );

    assign aluB = ctrl.aluSrc ? imm : rs2Data;

    alu uAlu (
        .a    (rs1Data),
        .b    (aluB),
        .op   (ctrl.aluOp),
        .y    (aluY),
        .zero (aluZero)
    );

    // Load/store port, only live while running
    assign memReq.valid = run & (ctrl.memRead | ctrl.memWrite);
    assign memReq.write = ctrl.memWrite;
    assign memReq.addr  = aluY[WordAw+1:2]; // Byte to word address
    assign memReq.wdata = rs2Data;

    // Host took the memory this cycle, retry next
    assign stall   = memReq.valid & ~grant;
    assign advance = run & ~stall;

    assign wbData = ctrl.memToReg ? memRdata : aluY;

    assign takeBranch = ctrl.branch & aluZero;
    assign nextPc     = takeBranch ? (pc + imm) : (pc + XLen'(4));

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (pcClear) begin
            pc <= '0; // Host restart
        end else if (advance) begin
            pc <= {nextPc[XLen-1:2], 2'b00}; // Keep word aligned
        end
    end

endmodule

`default_nettype wire

// File: logic/sharedMem.sv
`timescale 1ns/10ps
`default_nettype none

module sharedMem import cpuPkg::*; #(
    parameter int Depth = 256
) (
    input  wire logic              CLK,
    input  wire logic              we,
    input  wire logic [WordAw-1:0] waddr,
    input  wire logic [WordAw-1:0] raddr,
    input  wire logic [XLen-1:0]   wdata,
    output logic      [XLen-1:0]   rdata
);

    logic [XLen-1:0] mem [Depth];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr]; // Async read, same cycle

endmodule

`default_nettype wire

// File: logic/memArbiter.sv
`timescale 1ns/10ps
`default_nettype none

module memArbiter import cpuPkg::*; (
    input  wire logic               CLK,
    input  wire logic               rstN,
    input  wire apbReqT             apbReq,
    output apbRspT                  apbRsp,
    input  wire memReqT             coreReq,
    output logic                    grant,
    output logic       [XLen-1:0]   coreRdata,
    input  wire logic  [XLen-1:0]   pc,
    output logic                    run,
    output logic                    pcClear,
    output logic                    imemWe,
    output logic       [WordAw-1:0] imemAddr,
    output logic       [XLen-1:0]   imemWdata,
    output logic                    dmemWe,
    output logic       [WordAw-1:0] dmemAddr,
    output logic       [XLen-1:0]   dmemWdata,
    input  wire logic  [XLen-1:0]   dmemRdata
);

    logic              access;
    logic              hostWr;
    logic              isImem;
    logic              isDmem;
    logic              isCtrl;
    logic              isPc;
    logic              hostDmem;
    logic [WordAw-1:0] hostWordAddr;

    assign access       = apbReq.psel & apbReq.penable; // APB access phase
    assign hostWr       = access & apbReq.pwrite;
    assign hostWordAddr = apbReq.paddr[WordAw+1:2];

    // Region decode on the bits above the word index
    assign isImem = apbReq.paddr[PaddrW-1:WordAw+2] == ImemBase[PaddrW-1:WordAw+2];
    assign isDmem = apbReq.paddr[PaddrW-1:WordAw+2] == DmemBase[PaddrW-1:WordAw+2];
    assign isCtrl = apbReq.paddr == CtrlAddr;
    assign isPc   = apbReq.paddr == PcAddr;

    // Host owns dmem from setup phase on
    assign hostDmem  = apbReq.psel & isDmem;
    assign grant     = coreReq.valid & ~hostDmem;
    assign dmemAddr  = hostDmem ? hostWordAddr : coreReq.addr;
    assign dmemWdata = hostDmem ? apbReq.pwdata : coreReq.wdata;
    assign dmemWe    = hostDmem ? hostWr : (grant & coreReq.write);
    assign coreRdata = dmemRdata;

    // Instruction loads only while halted
    assign imemWe    = hostWr & isImem & ~run;
    assign imemAddr  = hostWordAddr;
    assign imemWdata = apbReq.pwdata;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            run <= 1'b0;
        end else if (hostWr && isCtrl) begin
            run <= apbReq.pwdata[0];
        end
    end

    // Lands on the same edge as run going high
    assign pcClear = hostWr & isCtrl & apbReq.pwdata[0];

    always_comb begin
        apbRsp.prdata  = '0;
        apbRsp.pready  = 1'b1; // No wait states
        apbRsp.pslverr = 1'b0;
        if (isDmem) begin
            apbRsp.prdata = dmemRdata;
        end else if (isCtrl) begin
            apbRsp.prdata = {{(XLen-1){1'b0}}, run};
        end else if (isPc) begin
            apbRsp.prdata  = pc;
            apbRsp.pslverr = hostWr;    // PC is read only
        end else if (isImem) begin
            apbRsp.pslverr = hostWr & run; // Imem reads return zero
        end else begin
            apbRsp.pslverr = access;    // Unmapped
        end
    end

endmodule

`default_nettype wire

// File: logic/cpuTop.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTop import cpuPkg::*; (
    input  wire logic   CLK,
    input  wire logic   rstN,
    input  wire apbReqT apbReq,
    output apbRspT      apbRsp
);

    logic              run;
    logic              pcClear;
    logic [XLen-1:0]   pc;
    logic [XLen-1:0]   instr;
    memReqT            memReq;
    logic              grant;
    logic [XLen-1:0]   coreRdata;
    logic              imemWe;
    logic [WordAw-1:0] imemAddr;
    logic [XLen-1:0]   imemWdata;
    logic              dmemWe;
    logic [WordAw-1:0] dmemAddr;
    logic [XLen-1:0]   dmemWdata;
    logic [XLen-1:0]   dmemRdata;

    coreDatapath uCore (
        .CLK      (CLK),
        .rstN     (rstN),
        .run      (run),
        .pcClear  (pcClear),
        .instr    (instr),
        .pc       (pc),
        .memReq   (memReq),
        .grant    (grant),
        .memRdata (coreRdata)
    );

    memArbiter uArbiter (
        .CLK       (CLK),
        .rstN      (rstN),
        .apbReq    (apbReq),
        .apbRsp    (apbRsp),
        .coreReq   (memReq),
        .grant     (grant),
        .coreRdata (coreRdata),
        .pc        (pc),
        .run       (run),
        .pcClear   (pcClear),
        .imemWe    (imemWe),
        .imemAddr  (imemAddr),
        .imemWdata (imemWdata),
        .dmemWe    (dmemWe),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata),
        .dmemRdata (dmemRdata)
    );

    // Fetch port driven by the PC, writes from the host only
    sharedMem #(.Depth(ImemDepth)) uImem (
        .CLK   (CLK),
        .we    (imemWe),
        .waddr (imemAddr),
        .raddr (pc[WordAw+1:2]),
        .wdata (imemWdata),
        .rdata (instr)
    );

    // One address for both ports, owner picked by the arbiter
    sharedMem #(.Depth(DmemDepth)) uDmem (
        .CLK   (CLK),
        .we    (dmemWe),
        .waddr (dmemAddr),
        .raddr (dmemAddr),
        .wdata (dmemWdata),
        .rdata (dmemRdata)
    );

endmodule

`default_nettype wire

// File: dv/cpuTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTb import cpuPkg::*; ();

    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 8;
    localparam int ProgLen     = 28;  // Words in the test program
    localparam int IterBound   = 16;  // Upper bound on executed instructions per program word
    localparam int ApbBudget   = 1200; // Host transfers over the whole run
    localparam int TimeoutNs   = (2 * ProgLen * IterBound + ApbBudget) * ClkPeriod * 4;

    logic        CLK;
    logic        rstN;
    apbReqT      apbReq;
    apbRspT      apbRsp;

    logic [31:0] lfsr;
    logic [31:0] prog [ImemDepth];   // Program image
    logic [31:0] expMem [DmemDepth]; // Expected data memory
    logic [31:0] xReg [32];          // Model registers
    logic [31:0] refPc;
    logic        checkReq;           // Stimulus asks for a full memory compare
    int          checkCount;
    int          valueErrs;
    int          rspErrs;

    cpuTop u_dut (
        .CLK    (CLK),
        .rstN   (rstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp)
    );

    initial begin
        CLK = 1'b0;
        forever #(ClkPeriod / 2) CLK = ~CLK;
    end

    // Fibonacci LFSR on taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Every address bit shows up in the word
    function automatic logic [31:0] fillWord(input logic [7:0] w);
        return {8'hD5, w, ~w, w ^ 8'h3C};
    endfunction

    // RV32I encodings
    function automatic logic [31:0] encR(input logic [2:0] f3, input logic isSub,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {1'b0, isSub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    // ISA model over prog, xReg and expMem that returns the self-loop PC
    function automatic logic [31:0] refRun();
        logic [31:0] pcM;
        logic [31:0] nextPc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] ea;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic        wr;
        pcM = '0;
        for (int n = 0; n < ProgLen * IterBound; n++) begin
            ins    = prog[pcM[9:2]];
            a      = xReg[ins[19:15]];
            b      = xReg[ins[24:20]];
            immI   = {{20{ins[31]}}, ins[31:20]};
            immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            nextPc = pcM + 32'd4;
            wr     = 1'b0;
            res    = '0;
            case (ins[6:0])
                7'b0110011: begin
                    wr = 1'b1;
                    case (ins[14:12])
                        3'b000:  res = ins[30] ? a - b : a + b;
                        3'b010:  res = {31'd0, $signed(a) < $signed(b)};
                        3'b110:  res = a | b;
                        3'b111:  res = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                7'b0010011: begin   // addi only
                    wr  = (ins[14:12] == 3'b000);
                    res = a + immI;
                end
                7'b0000011: begin   // lw
                    wr  = 1'b1;
                    ea  = a + immI;
                    res = expMem[ea[9:2]];
                end
                7'b0100011: begin   // sw
                    ea = a + immS;
                    expMem[ea[9:2]] = b;
                end
                7'b1100011: if (a == b) nextPc = pcM + immB; // beq
                default: ;
            endcase
            if (wr && ins[11:7] != 5'd0) xReg[ins[11:7]] = res;
            if (nextPc == pcM) return pcM; // Self-loop reached
            pcM = nextPc;
        end
        return 32'hFFFF_FFFF;
    endfunction

    task automatic checkVal(input logic [31:0] got, input logic [31:0] exp, input string what);
        checkCount++;
        assert (got === exp) else begin
            valueErrs++;
            $display("error %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkErr(input logic got, input logic exp, input logic [15:0] addr);
        checkCount++;
        assert (got === exp) else begin
            rspErrs++;
            $display("error %0t: pslverr %b at address %h, expected %b", $time, got, addr, exp);
        end
    endtask

    // Setup and access phase followed by an idle cycle
    task automatic apbXfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
        @(negedge CLK);
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = wr;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(negedge CLK);
        apbReq.penable = 1'b1;
        #(ClkPeriod / 4);    // Settled well before the rising edge
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        checkCount++;
        assert (apbRsp.pready === 1'b1) else begin // No wait states
            rspErrs++;
            $display("error %0t: pready low in the access phase at address %h", $time, addr);
        end
        @(negedge CLK);
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b0;
    endtask

    task automatic hostWrite(input logic [15:0] addr, input logic [31:0] data, input logic expErr);
        logic [31:0] rd;
        logic        err;
        apbXfer(1'b1, addr, data, rd, err);
        checkErr(err, expErr, addr);
    endtask

    task automatic hostRead(input logic [15:0] addr, output logic [31:0] data, input logic expErr);
        logic err;
        apbXfer(1'b0, addr, '0, data, err);
        checkErr(err, expErr, addr);
    endtask

    // Arithmetic, load/store, x0 and a counted loop with random operands
    task automatic buildProgram();
        logic [11:0] immA;
        logic [11:0] immB;
        logic [11:0] loops;
        immA  = 12'(randBits(12));
        immB  = 12'(randBits(12));
        loops = 12'(3 + randBits(3)); // 3 to 10 passes
        prog[0]  = encI(OpImm, 3'b000, 5'd1, 5'd0, immA);
        prog[1]  = encI(OpImm, 3'b000, 5'd2, 5'd0, immB);
        prog[2]  = encR(3'b000, 1'b0, 5'd3, 5'd1, 5'd2); // add
        prog[3]  = encR(3'b000, 1'b1, 5'd4, 5'd1, 5'd2); // sub
        prog[4]  = encR(3'b111, 1'b0, 5'd5, 5'd1, 5'd2); // and
        prog[5]  = encR(3'b110, 1'b0, 5'd6, 5'd1, 5'd2); // or
        prog[6]  = encR(3'b010, 1'b0, 5'd7, 5'd1, 5'd2); // slt
        prog[7]  = encS(5'd3, 5'd0, 12'd0);
        prog[8]  = encS(5'd4, 5'd0, 12'd4);
        prog[9]  = encS(5'd5, 5'd0, 12'd8);
        prog[10] = encS(5'd6, 5'd0, 12'd12);
        prog[11] = encS(5'd7, 5'd0, 12'd16);
        prog[12] = encI(OpLoad, 3'b010, 5'd8, 5'd0, 12'd0);
        prog[13] = encR(3'b000, 1'b0, 5'd9, 5'd8, 5'd4); // Uses load result
        prog[14] = encS(5'd9, 5'd0, 12'd20);
        prog[15] = encI(OpImm, 3'b000, 5'd0, 5'd0, immA); // Write to x0
        prog[16] = encS(5'd0, 5'd0, 12'd24);
        prog[17] = encI(OpImm, 3'b000, 5'd10, 5'd0, 12'd0);
        prog[18] = encI(OpImm, 3'b000, 5'd11, 5'd0, loops);
        prog[19] = encI(OpImm, 3'b000, 5'd10, 5'd10, 12'd1); // Loop head
        prog[20] = encS(5'd10, 5'd0, 12'd28);
        prog[21] = encB(5'd10, 5'd11, 13'd8);      // Exit when done
        prog[22] = encB(5'd0, 5'd0, 13'h1FF4);     // Back by 12
        prog[23] = encS(5'd10, 5'd0, 12'd32);
        prog[24] = encI(OpLoad, 3'b010, 5'd12, 5'd0, 12'd28);
        prog[25] = encR(3'b010, 1'b0, 5'd13, 5'd2, 5'd12);
        prog[26] = encS(5'd13, 5'd0, 12'd36);
        prog[27] = encB(5'd0, 5'd0, 13'd0);        // Self-loop
    endtask

    // One random host access in the upper half that the program never touches
    task automatic hostTraffic();
        logic [WordAw-1:0] w;
        logic [31:0]       d;
        logic [31:0]       rd;
        logic [15:0]       a;
        w = {1'b1, 7'(randBits(7))};
        a = DmemBase + {6'd0, w, 2'b00};
        if (randBits(1) == 32'd1) begin
            d = randBits(32);
            hostWrite(a, d, 1'b0);
            expMem[w] = d;
        end else begin
            hostRead(a, rd, 1'b0);
            checkVal(rd, expMem[w], "host region word");
        end
    endtask

    task automatic runProgram(input logic withTraffic);
        logic [31:0] p1;
        logic [31:0] p2;
        buildProgram();
        for (int i = 0; i < ProgLen; i++) begin
            hostWrite(ImemBase + 16'(4 * i), prog[i], 1'b0); // Accepted while halted
        end
        refPc = refRun();
        hostWrite(CtrlAddr, 32'd1, 1'b0); // Start from PC 0
        if (withTraffic) begin
            // Would break the self-loop if it got through
            hostWrite(ImemBase + 16'(4 * (ProgLen - 1)), 32'hFFFF_FFFF, 1'b1);
        end
        p1 = 32'hFFFF_FFFF;
        p2 = '0;
        while (p1 !== p2) begin
            if (withTraffic) repeat (3) hostTraffic();
            hostRead(PcAddr, p1, 1'b0);
            hostRead(PcAddr, p2, 1'b0); // No host dmem access in between
        end
        hostWrite(CtrlAddr, 32'd0, 1'b0); // Halt
        checkVal(p2, refPc, "final PC");
        checkReq = 1'b1;
        wait (checkReq === 1'b0);
    endtask

    initial begin : stimulus
        logic [31:0] rd;
        logic [31:0] d;
        apbReq     = '0;
        rstN       = 1'b0;
        checkReq   = 1'b0;
        checkCount = 0;
        valueErrs  = 0;
        rspErrs    = 0;
        lfsr       = 32'd96157;
        refPc      = '0;
        for (int i = 0; i < 32; i++) xReg[i] = '0; // Matches the register reset
        repeat (ResetCycles) @(posedge CLK);
        @(negedge CLK);
        rstN = 1'b1;

        hostRead(PcAddr, rd, 1'b0);
        checkVal(rd, 32'd0, "PC after reset");
        hostRead(CtrlAddr, rd, 1'b0);
        checkVal(rd, 32'd0, "run after reset");
        d = randBits(32);
        hostWrite(DmemBase + 16'h0300, d, 1'b0);
        hostRead(DmemBase + 16'h0300, rd, 1'b0);
        checkVal(rd, d, "dmem write and read back");

        // Error responses while halted
        hostRead(16'h3000, rd, 1'b1);            // Unmapped
        hostWrite(16'h2008, 32'd5, 1'b1);        // Unmapped
        hostWrite(PcAddr, 32'h0000_0040, 1'b1);  // Read only

        for (int i = 0; i < DmemDepth; i++) begin
            expMem[i] = fillWord(8'(i));
            hostWrite(DmemBase + 16'(4 * i), expMem[i], 1'b0);
        end

        runProgram(1'b0); // Quiet bus
        runProgram(1'b1); // Host traffic while running

        $display("Checks %0d, value errors %0d, response errors %0d",
                 checkCount, valueErrs, rspErrs);
        if (valueErrs + rspErrs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Full dmem read back against the model
    initial begin : compare
        logic [31:0] rd;
        forever begin
            wait (checkReq === 1'b1);
            for (int i = 0; i < DmemDepth; i++) begin
                hostRead(DmemBase + 16'(4 * i), rd, 1'b0);
                checkVal(rd, expMem[i], $sformatf("dmem word %0d", i));
            end
            checkReq = 1'b0;
        end
    end

    initial begin : watchdog
        #(TimeoutNs);
        $display("Simulation timed out after %0d ns before all tests finished", TimeoutNs);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
logic/cpuPkg.sv
logic/regFile.sv
logic/instrDecoder.sv
logic/alu.sv
logic/coreDatapath.sv
logic/sharedMem.sv
logic/memArbiter.sv
logic/cpuTop.sv
dv/cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module cpuTb -f src.f -o cpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
